//--- design/helios_pkg.sv
package helios_pkg;

    // ******************************************************************
    // code size
    // ******************************************************************
    localparam int code_distance = 7;                    // data qubits.
    localparam int syndrome_count = code_distance - 1;   // stabilizers.
    localparam int qubit_index_width = $clog2(code_distance);

    // ******************************************************************
    // memory record and credit flow
    // ******************************************************************
    localparam int credit_max = 4;       // word slots in the sink.
    localparam int record_words = 2;     // words per run record.

    // error source random generator.
    localparam logic [31:0] lfsr_seed = 32'h1f2e_3d4c;
    localparam logic [31:0] lfsr_poly = 32'h8020_0003;

    typedef logic [code_distance-1:0]     qubit_vec_t;
    typedef logic [syndrome_count-1:0]    syndrome_t;
    typedef logic [qubit_index_width-1:0] qubit_index_t;
    typedef logic [15:0]                  cycle_count_t;
    typedef logic [15:0]                  run_count_t;
    typedef logic [31:0]                  word_t;
    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  lfsr_t;
    typedef logic [7:0]                   threshold_t;
    typedef logic [2:0]                   credit_t;
    typedef logic [1:0]                   reg_addr_t;
    typedef logic [15:0]                  reg_data_t;

    typedef enum logic [2:0] {
        stage_idle,
        stage_loading,
        stage_scanning,
        stage_resolving,
        stage_result
    } stage_t;

endpackage

//--- design/error_source.sv
module error_source
    import helios_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       new_round_start,
    input  threshold_t error_threshold,
    output qubit_vec_t errors,
    output syndrome_t  measurements,
    output logic       syndrome_valid,
    output logic       source_idle
);

    lfsr_t        lfsr_state;
    lfsr_t        lfsr_next;
    threshold_t   draw;
    qubit_index_t draw_index;
    qubit_index_t current_index;
    logic         drawing;
    logic         forming;

    // eight galois steps per cycle, one output bit each.
    always_comb begin
        lfsr_next = lfsr_state;
        draw = '0;
        for (int i = 0; i < 8; i++) begin
            draw[i] = lfsr_next[0];
            lfsr_next = (lfsr_next >> 1) ^ (lfsr_next[0] ? lfsr_poly : '0);
        end
    end

    assign current_index = new_round_start ? '0 : draw_index; // qubit 0 on the start pulse.
    assign source_idle = !(drawing || forming || syndrome_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_state <= lfsr_seed;
            draw_index <= '0;
            drawing <= 1'b0;
            forming <= 1'b0;
            syndrome_valid <= 1'b0;
        end else begin
            syndrome_valid <= forming;
            if (new_round_start || drawing) begin
                lfsr_state <= lfsr_next;
                if (current_index == qubit_index_t'(code_distance - 1)) begin
                    drawing <= 1'b0;
                    forming <= 1'b1;  // last qubit decided.
                end else begin
                    drawing <= 1'b1;
                    forming <= 1'b0;
                    draw_index <= current_index + 1'b1;
                end
            end else begin
                forming <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_round_start || drawing) begin
            errors[current_index] <= (draw < error_threshold);
        end
        if (forming) begin
            measurements <= errors[syndrome_count-1:0] ^ errors[code_distance-1:1];
        end
    end

endmodule

//--- design/chain_decoder.sv
module chain_decoder
    import helios_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         syndrome_valid,
    input  syndrome_t    measurements,
    output qubit_vec_t   correction,
    output logic         result_valid,
    output stage_t       global_stage,
    output cycle_count_t cycle_counter,
    output logic         decoder_idle
);

    stage_t       stage;
    syndrome_t    syndrome_reg;
    qubit_vec_t   candidate;
    qubit_index_t scan_index;
    qubit_index_t prev_index;
    qubit_index_t flip_count;
    cycle_count_t cycle_count;
    logic         next_flip;

    // ******************************************************************
    // stage machine and duration counter
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            cycle_count <= '0;
        end else begin
            if (stage != stage_idle && stage != stage_result) begin
                cycle_count <= cycle_count + 1'b1;
            end
            unique case (stage)
                stage_idle: begin
                    if (syndrome_valid) begin
                        stage <= stage_loading;
                        cycle_count <= cycle_count_t'(1);  // loading is cycle one.
                    end
                end
                stage_loading: begin
                    stage <= stage_scanning;
                end
                stage_scanning: begin
                    if (scan_index == qubit_index_t'(code_distance - 1)) begin
                        stage <= stage_resolving;
                    end
                end
                stage_resolving: begin
                    stage <= stage_result;
                end
                stage_result: begin
                    stage <= stage_idle;
                end
                default: begin
                    stage <= stage_idle;
                end
            endcase
        end
    end

    // ******************************************************************
    // chain walk
    // ******************************************************************
    assign prev_index = scan_index - 1'b1;
    assign next_flip = candidate[prev_index] ^ syndrome_reg[prev_index];

    always_ff @(posedge clk) begin
        case (stage)
            stage_idle: begin
                if (syndrome_valid) begin
                    syndrome_reg <= measurements;
                end
            end
            stage_loading: begin
                // qubit 0 stays, qubit 1 follows the first stabilizer.
                candidate <= qubit_vec_t'({syndrome_reg[0], 1'b0});
                flip_count <= qubit_index_t'(syndrome_reg[0]);
                scan_index <= qubit_index_t'(2);
            end
            stage_scanning: begin
                candidate[scan_index] <= next_flip;
                flip_count <= flip_count + qubit_index_t'(next_flip);
                scan_index <= scan_index + 1'b1;
            end
            stage_resolving: begin
                if ((32'(flip_count) << 1) > code_distance) begin
                    correction <= ~candidate;  // complement is lighter.
                end else begin
                    correction <= candidate;
                end
            end
            default: begin
            end
        endcase
    end

    assign result_valid = (stage == stage_result);
    assign decoder_idle = (stage == stage_idle);
    assign global_stage = stage;
    assign cycle_counter = cycle_count;

endmodule

//--- design/run_config_regs.sv
module run_config_regs
    import helios_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       reg_write,
    input  reg_addr_t  reg_addr,
    input  reg_data_t  reg_wdata,
    input  run_count_t runs_done,
    output reg_data_t  reg_rdata,
    output logic       enable,
    output run_count_t run_limit,
    output threshold_t error_threshold
);

    // ******************************************************************
    // register map
    // ******************************************************************
    localparam reg_addr_t addr_control = 2'd0;
    localparam reg_addr_t addr_run_limit = 2'd1;
    localparam reg_addr_t addr_threshold = 2'd2;
    localparam reg_addr_t addr_runs_done = 2'd3;

    reg_data_t control_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            control_reg <= '0;
            run_limit <= '0;
            error_threshold <= '0;
        end else if (reg_write) begin
            case (reg_addr)
                addr_control: control_reg <= reg_wdata;
                addr_run_limit: run_limit <= reg_wdata;
                addr_threshold: error_threshold <= reg_wdata[7:0];
                default: begin  // status is read only.
                end
            endcase
        end
    end

    always_comb begin
        case (reg_addr)
            addr_control: reg_rdata = control_reg;
            addr_run_limit: reg_rdata = run_limit;
            addr_threshold: reg_rdata = reg_data_t'(error_threshold);
            addr_runs_done: reg_rdata = runs_done;
            default: reg_rdata = '0;
        endcase
    end

    assign enable = control_reg[0];  // bit 0 of control.

endmodule

//--- design/host_link.sv
module host_link
    import helios_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  run_count_t   run_limit,
    input  logic         result_valid,
    input  qubit_vec_t   correction,
    input  cycle_count_t cycle_counter,
    input  logic         decoder_idle,
    input  logic         source_idle,
    input  logic         credit_return,
    output logic         new_round_start,
    output run_count_t   runs_done,
    output logic         bram_en,
    output logic [3:0]   bram_we,
    output addr_t        bram_addr,
    output word_t        bram_di
);

    credit_t credits;
    logic    round_active;
    logic    word0_active;
    logic    word1_active;
    logic    start_ok;

    // a round only starts with room for its whole record.
    assign start_ok = enable && (runs_done < run_limit) && decoder_idle && source_idle
                      && !round_active && (credits >= credit_t'(record_words));

    always_ff @(posedge clk) begin
        if (reset) begin
            new_round_start <= 1'b0;
            round_active <= 1'b0;
            word0_active <= 1'b0;
            word1_active <= 1'b0;
            credits <= credit_t'(credit_max);
            runs_done <= '0;
            bram_addr <= '0;
        end else begin
            new_round_start <= start_ok;
            word0_active <= result_valid;
            word1_active <= word0_active;
            if (start_ok) begin
                round_active <= 1'b1;
            end else if (word1_active) begin
                round_active <= 1'b0;  // record complete.
            end

            case ({bram_en, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: begin
                end
            endcase

            if (word1_active) begin
                runs_done <= runs_done + 1'b1;
            end else if (!enable && !round_active) begin
                runs_done <= '0;
            end

            if (bram_en) begin
                bram_addr <= bram_addr + addr_t'(4);
            end else if (!enable && !round_active) begin
                bram_addr <= '0;
            end
        end
    end

    assign bram_en = word0_active || word1_active;
    assign bram_we = bram_en ? 4'hf : 4'h0;
    assign bram_di = word0_active ? {runs_done, 16'(correction)} : word_t'(cycle_counter);

endmodule

//--- design/helios_repetition_top.sv
module helios_repetition_top
    import helios_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         reg_write,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    input  logic         credit_return,
    input  word_t        bram_dout,
    output reg_data_t    reg_rdata,
    output logic         new_round_start,
    output qubit_vec_t   errors,
    output syndrome_t    measurements,
    output qubit_vec_t   correction,
    output logic         result_valid,
    output cycle_count_t cycle_counter,
    output stage_t       global_stage,
    output logic [3:0]   bram_we,
    output logic         bram_en,
    output addr_t        bram_addr,
    output word_t        bram_di
);

    logic       enable;
    run_count_t run_limit;
    run_count_t runs_done;
    threshold_t error_threshold;
    logic       syndrome_valid;
    logic       source_idle;
    logic       decoder_idle;

    // ******************************************************************
    // host side
    // ******************************************************************
    run_config_regs regs (
        .clk(clk),
        .reset(reset),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .runs_done(runs_done),
        .reg_rdata(reg_rdata),
        .enable(enable),
        .run_limit(run_limit),
        .error_threshold(error_threshold)
    );

    host_link link (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .run_limit(run_limit),
        .result_valid(result_valid),
        .correction(correction),
        .cycle_counter(cycle_counter),
        .decoder_idle(decoder_idle),
        .source_idle(source_idle),
        .credit_return(credit_return),
        .new_round_start(new_round_start),
        .runs_done(runs_done),
        .bram_en(bram_en),
        .bram_we(bram_we),
        .bram_addr(bram_addr),
        .bram_di(bram_di)
    );

    // ******************************************************************
    // error generation and decoding
    // ******************************************************************
    error_source source (
        .clk(clk),
        .reset(reset),
        .new_round_start(new_round_start),
        .error_threshold(error_threshold),
        .errors(errors),
        .measurements(measurements),
        .syndrome_valid(syndrome_valid),
        .source_idle(source_idle)
    );

    chain_decoder decoder (
        .clk(clk),
        .reset(reset),
        .syndrome_valid(syndrome_valid),
        .measurements(measurements),
        .correction(correction),
        .result_valid(result_valid),
        .global_stage(global_stage),
        .cycle_counter(cycle_counter),
        .decoder_idle(decoder_idle)
    );

endmodule

//--- test/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // period of 4.
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- test/tb_helios.sv
module tb_helios
    import helios_pkg::*;
();

    localparam int total_runs = 31;
    localparam int timeout_limit = 4 * total_runs * 16 + 2000;

    logic clk, reset, reg_write, credit_return, new_round_start, result_valid, bram_en;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata, reg_rdata;
    word_t bram_dout, bram_di;
    qubit_vec_t errors, correction;
    syndrome_t measurements;
    cycle_count_t cycle_counter;
    stage_t global_stage;
    logic [3:0] bram_we;
    addr_t bram_addr;

    string current_test = "reset";
    int error_count = 0, check_count = 0, test_errors = 0;
    int cycle = 0, start_count = 0, write_count = 0, drain_wait = 0, last_write_cycle = 0;
    int start_cycle = 0;
    int expect_mode = 0;  // 1 clean, 2 heavy.
    logic stall_credits = 1'b0, word_parity = 1'b0;
    addr_t expected_addr = '0;
    run_count_t expected_index = '0;
    word_t sink_queue[$];
    qubit_vec_t expected_corrections[$];
    logic [15:0] random_state = 16'd62;

    clock_gen clocks (.clk(clk), .reset(reset));

    helios_repetition_top uut (
        .clk(clk), .reset(reset), .reg_write(reg_write), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .credit_return(credit_return), .bram_dout(bram_dout),
        .reg_rdata(reg_rdata), .new_round_start(new_round_start), .errors(errors),
        .measurements(measurements), .correction(correction), .result_valid(result_valid),
        .cycle_counter(cycle_counter), .global_stage(global_stage), .bram_we(bram_we),
        .bram_en(bram_en), .bram_addr(bram_addr), .bram_di(bram_di)
    );

    initial begin
        reg_write = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        credit_return = 1'b0;
        bram_dout = '0;
    end

    // **********************************************************************
    // reference rules and helpers
    // **********************************************************************
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", current_test, name,
                     expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s: %s", current_test, what);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic threshold_t next_random_byte();
        threshold_t value;
        for (int i = 0; i < 8; i++) begin
            value[i] = random_state[0];  // one step per bit.
            random_state = lfsr_step(random_state);
        end
        return value;
    endfunction

    function automatic syndrome_t syndrome_of(input qubit_vec_t q);
        syndrome_t s;
        for (int k = 0; k < syndrome_count; k++) begin
            s[k] = q[k] ^ q[k+1];
        end
        return s;
    endfunction

    function automatic int count_ones(input qubit_vec_t q);
        int n;
        n = 0;
        for (int k = 0; k < code_distance; k++) begin
            n += q[k];
        end
        return n;
    endfunction

    function automatic qubit_vec_t min_weight_correction(input syndrome_t s);
        qubit_vec_t c;
        c = '0;  // qubit 0 uncorrected.
        for (int k = 0; k < syndrome_count; k++) begin
            c[k+1] = c[k] ^ s[k];
        end
        if (2 * count_ones(c) > code_distance) begin
            c = ~c;
        end
        return c;
    endfunction

    // **********************************************************************
    // monitors, memory sink and timeout
    // **********************************************************************
    always @(negedge clk) begin
        if (!reset && new_round_start) begin
            start_count++;
            start_cycle = cycle;
        end
        if (!reset && result_valid) begin
            check_value("latency", 2 * code_distance + 2, cycle - start_cycle);
            check_value("result stage", stage_result, global_stage);
            check_value("syndrome", syndrome_of(errors), measurements);
            check_value("correction", min_weight_correction(measurements), correction);
            check_value("residual syndrome", syndrome_of(errors), syndrome_of(correction));
            check_value("duration", code_distance + 1, cycle_counter);
            if (expect_mode == 1) begin
                check_value("clean errors", 0, errors);
                check_value("clean correction", 0, correction);
            end else if (expect_mode == 2) begin
                check_value("heavy errors", 1, count_ones(errors) > code_distance / 2);
            end
            expected_corrections.push_back(min_weight_correction(measurements));
        end
    end

    always @(posedge clk) begin
        cycle++;
        credit_return <= 1'b0;
        if (bram_en) begin
            check_value("bram_we", 4'hf, bram_we);
            check_value("bram_addr", expected_addr, bram_addr);
            if (!word_parity) begin
                if (expected_corrections.size() == 0) begin
                    report_failure("a record was written without a decoded result");
                end else begin
                    check_value("word 0",
                                {expected_index, 16'(expected_corrections.pop_front())},
                                bram_di);
                end
            end else begin
                check_value("word 1", code_distance + 1, bram_di);
                if (cycle != last_write_cycle + 1) begin
                    report_failure("a record was split across non-adjacent cycles");
                end
                expected_index++;
            end
            word_parity = ~word_parity;
            expected_addr += 4;
            last_write_cycle = cycle;
            write_count++;
            sink_queue.push_back(bram_di);
            if (sink_queue.size() > credit_max) begin
                report_failure("more words outstanding than the sink can hold");
            end
        end
        if (!stall_credits && sink_queue.size() > 0) begin
            if (drain_wait == 2) begin
                void'(sink_queue.pop_front());
                credit_return <= 1'b1;  // one credit per drained word.
                drain_wait = 0;
            end else begin
                drain_wait++;
            end
        end
        if (cycle > timeout_limit) begin
            $display("the run timed out after %0d cycles in %s", cycle, current_test);
            $display("Checks failed");
            $finish;
        end
    end

    // **********************************************************************
    // host bus tasks
    // **********************************************************************
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        reg_write <= 1'b1;
        reg_addr <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_write <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic wait_runs(input int count);
        reg_data_t value;
        read_reg(2'd3, value);
        while (value != count) begin
            read_reg(2'd3, value);
        end
    endtask

    task automatic stop_runs();
        write_reg(2'd0, 16'h0000);
        wait_runs(0);
        expected_addr = '0;  // harness restarts at address 0.
        expected_index = '0;
        word_parity = 1'b0;
    endtask

    task automatic start_runs(input threshold_t threshold, input int limit);
        stop_runs();
        write_reg(2'd2, reg_data_t'(threshold));
        write_reg(2'd1, reg_data_t'(limit));
        write_reg(2'd0, 16'h0001);
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", current_test, error_count - test_errors);
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************
    task automatic register_access();
        reg_data_t value;
        begin_test("registers");
        @(negedge clk);
        check_value("reset new_round_start", 0, new_round_start);
        check_value("reset result_valid", 0, result_valid);
        check_value("reset bram_en", 0, bram_en);
        check_value("reset global_stage", stage_idle, global_stage);
        for (int a = 0; a < 4; a++) begin
            read_reg(reg_addr_t'(a), value);
            check_value("reset readback", 0, value);
        end
        write_reg(2'd0, 16'h00a6);  // enable bit stays 0.
        write_reg(2'd1, 16'h1234);
        write_reg(2'd2, 16'h5a7c);
        write_reg(2'd3, 16'hffff);
        read_reg(2'd0, value);
        check_value("control readback", 16'h00a6, value);
        read_reg(2'd1, value);
        check_value("run_limit readback", 16'h1234, value);
        read_reg(2'd2, value);
        check_value("threshold readback", 16'h007c, value);
        read_reg(2'd3, value);
        check_value("runs_done readback", 0, value);
        write_reg(2'd1, 16'h0000);
        write_reg(2'd2, 16'h0000);
        end_test();
    endtask

    task automatic extreme_thresholds();
        begin_test("extremes");
        expect_mode = 1;
        start_runs(8'd0, 3);
        wait_runs(3);
        expect_mode = 2;
        start_runs(8'd255, 3);
        wait_runs(3);
        expect_mode = 0;
        end_test();
    endtask

    task automatic random_decoding();
        begin_test("random decoding");
        start_runs(8'd0, 0);
        for (int k = 1; k <= 8; k++) begin
            write_reg(2'd2, reg_data_t'(next_random_byte()));
            write_reg(2'd1, reg_data_t'(k));
            wait_runs(k);
        end
        end_test();
    endtask

    task automatic record_stream();
        int starts, writes;
        reg_data_t value;
        begin_test("record stream");
        stop_runs();
        starts = start_count;
        writes = write_count;
        start_runs(next_random_byte(), 4);
        wait_runs(4);
        repeat (40) @(posedge clk);
        read_reg(2'd3, value);
        check_value("runs_done", 4, value);
        check_value("starts", 4, start_count - starts);
        check_value("writes", 8, write_count - writes);
        end_test();
    endtask

    task automatic credit_back_pressure();
        int starts;
        reg_data_t value;
        begin_test("back pressure");
        stop_runs();
        starts = start_count;
        stall_credits = 1'b1;
        start_runs(next_random_byte(), 5);
        repeat (80) @(posedge clk);
        read_reg(2'd3, value);
        check_value("stalled runs_done", credit_max / record_words, value);
        check_value("stalled starts", credit_max / record_words, start_count - starts);
        stall_credits = 1'b0;
        wait_runs(5);
        end_test();
    endtask

    task automatic enable_drop();
        int starts, writes;
        begin_test("enable drop");
        start_runs(next_random_byte(), 6);
        wait_runs(2);
        stop_runs();  // current record finishes first.
        starts = start_count;
        repeat (40) @(posedge clk);
        check_value("disabled starts", starts, start_count);
        writes = write_count;
        start_runs(next_random_byte(), 2);
        wait_runs(2);
        check_value("restart writes", 4, write_count - writes);
        stop_runs();
        end_test();
    endtask

    initial begin
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        register_access();
        extreme_thresholds();
        random_decoding();
        record_stream();
        credit_back_pressure();
        enable_drop();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- files.f
design/helios_pkg.sv
design/error_source.sv
design/chain_decoder.sv
design/run_config_regs.sv
design/host_link.sv
design/helios_repetition_top.sv
test/clock_gen.sv
test/tb_helios.sv

//--- Bender.yml
package:
  name: helios_repetition

sources:
  - design/helios_pkg.sv
  - design/error_source.sv
  - design/chain_decoder.sv
  - design/run_config_regs.sv
  - design/host_link.sv
  - design/helios_repetition_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/tb_helios.sv
